// ==== files.f ====
hdl/macPkg.sv
hdl/mulPPGenSgn.sv
hdl/compressorSlice.sv
hdl/addMopCsv.sv
hdl/prefixAdder.sv
hdl/mulAddSgn.sv
hdl/macSequencer.sv
hdl/macTop.sv
sim/macChecker.sv
sim/tbMac.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbMac -f files.f -o tbMac
out="$(./obj_dir/tbMac)"
echo "$out"
if grep -qx "Finished with no errors" <<< "$out"; then
	exit 0
fi
exit 1

// ==== sim/tbMac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMac;

	localparam int waitLimit = 60;   // cycles, longest rspAck delay is 20

	logic          clk;
	logic          rstN;
	logic          inReq;
	macPkg::macReq inData;
	logic          inAck;
	logic          rspReq;
	macPkg::macRsp rspData;
	logic          rspAck;
	logic [31:0]   rngState;
	logic          aborted;   // a wait timed out

	macTop dut0 (.*);

	macChecker chk (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// xorshift32
	function automatic logic [31:0] nextRand();
		logic [31:0] s;
		s = rngState;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rngState = s;
		return s;
	endfunction

	function automatic macPkg::macReq randReq(input logic first, input logic last);
		logic [31:0] r;
		r = nextRand();
		return macPkg::macReq'{x: r[7:0], y: r[15:8], first: first, last: last};
	endfunction

	// onRsp selects rspReq, otherwise inAck
	task automatic waitLevel(input logic onRsp, input logic level);
		int   n;
		logic seen;
		n = 0;
		seen = ~level;
		if (aborted) begin
			return;
		end
		do begin
			@(posedge clk);
			seen = onRsp ? rspReq : inAck;
			n++;
		end while (seen !== level && n < waitLimit);
		if (seen !== level) begin
			chk.noteFailure($sformatf("timeout, %s did not go to %0b within %0d cycles",
				onRsp ? "rspReq" : "inAck", level, waitLimit));
			aborted = 1'b1;
		end
	endtask

	task automatic raiseReq(input macPkg::macReq item);
		inReq <= 1'b1;
		inData <= item;
	endtask

	// phases two to four of the input side
	task automatic finishReq();
		waitLevel(1'b0, 1'b1);
		inReq <= 1'b0;
		waitLevel(1'b0, 1'b0);
	endtask

	task automatic takeResult();
		waitLevel(1'b1, 1'b1);
		repeat (nextRand() % 21) begin   // 0 to 20 cycles of back-pressure
			@(posedge clk);
		end
		rspAck <= 1'b1;
		waitLevel(1'b1, 1'b0);
		rspAck <= 1'b0;
	endtask

	task automatic sendItem(input macPkg::macReq item);
		raiseReq(item);
		finishReq();
		if (item.last) begin
			takeResult();
		end
	endtask

	initial begin
		int len;

		rngState = 32'hbfd8_e90d;
		aborted = 1'b0;
		rstN = 1'b0;
		inReq = 1'b0;
		inData = '0;
		rspAck = 1'b0;

		chk.startTest("afterReset");
		repeat (5) begin
			@(posedge clk);
		end
		rstN <= 1'b1;
		repeat (2) begin
			@(posedge clk);
		end
		chk.finishTest();

		chk.startTest("singleProducts");
		sendItem(macPkg::macReq'{x: 8'h80, y: 8'h80, first: 1'b1, last: 1'b1});
		sendItem(macPkg::macReq'{x: 8'h80, y: 8'h7f, first: 1'b1, last: 1'b1});
		sendItem(macPkg::macReq'{x: 8'h00, y: 8'h00, first: 1'b1, last: 1'b1});
		sendItem(macPkg::macReq'{x: 8'h00, y: 8'h80, first: 1'b1, last: 1'b1});
		sendItem(macPkg::macReq'{x: 8'h7f, y: 8'h7f, first: 1'b1, last: 1'b1});
		sendItem(macPkg::macReq'{x: 8'hff, y: 8'hff, first: 1'b1, last: 1'b1});
		for (int n = 0; n < 30; n++) begin
			sendItem(randReq(1'b1, 1'b1));
		end
		chk.finishTest();

		chk.startTest("dotProducts");
		for (int n = 0; n < 40; n++) begin
			len = nextRand() % 16 + 1;
			for (int k = 0; k < len; k++) begin
				sendItem(randReq(k == 0 && n % 4 != 3, k == len - 1));   // every 4th keeps the old sum
			end
		end
		chk.finishTest();

		chk.startTest("wrap");
		for (int k = 0; k < 200; k++) begin
			// 2**14 per item, wraps every 64
			sendItem(macPkg::macReq'{x: 8'h80, y: 8'h80, first: k == 0, last: k % 25 == 24});
		end
		chk.finishTest();

		chk.startTest("backPressure");
		for (int n = 0; n < 30; n++) begin
			raiseReq(randReq(n == 0, 1'b1));
			finishReq();
			raiseReq(randReq(nextRand() % 2 == 0, 1'b1));   // waits behind the pending result
			takeResult();
			finishReq();
			takeResult();
		end
		chk.finishTest();

		chk.startTest("handshakeOrder");
		for (int n = 0; n < 40; n++) begin
			repeat (nextRand() % 4) begin
				@(posedge clk);
			end
			sendItem(randReq(n % 5 == 0, n % 5 == 4));
		end
		chk.finishTest();

		chk.reportCounts();
		if (chk.errCount == 0 && !aborted) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/macChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module macChecker (
	input logic          clk,
	input logic          rstN,
	input logic          inReq,
	input macPkg::macReq inData,
	input logic          inAck,
	input logic          rspReq,
	input macPkg::macRsp rspData,
	input logic          rspAck
);

	string        testName = "none";
	int           errCount = 0;
	int           checkCount = 0;
	int           testCount = 0;
	int           errAtStart = 0;      // errCount when the current test began
	macPkg::accum modelAcc;
	macPkg::accum expQ[$];             // sums still owed on the response port
	macPkg::accum heldSum;             // rspData seen at the rspReq rise
	logic         prevInAck = 1'b0;
	logic         prevRspReq = 1'b0;
	logic         prevRspAck = 1'b0;
	logic         canAccept = 1'b0;    // last edge had an acceptable request
	logic         resetChecked = 1'b0;

	task automatic startTest(input string name);
		testName = name;
		errAtStart = errCount;
	endtask

	task automatic finishTest();
		testCount++;
		$display("test %s: %s, %0d errors", testName,
			(errCount == errAtStart) ? "ok" : "FAILED", errCount - errAtStart);
	endtask

	task automatic noteFailure(input string what);
		errCount++;
		$display("error in %s: %s", testName, what);
	endtask

	task automatic reportCounts();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
	endtask

	// values read here are the ones from before the edge
	always @(posedge clk) begin
		int           prodV;
		macPkg::accum base;
		macPkg::accum expSum;

		if (!rstN) begin
			modelAcc = '0;
			expQ.delete();
			prevInAck = 1'b0;
			prevRspReq = 1'b0;
			prevRspAck = 1'b0;
			canAccept = 1'b0;
		end else begin
			if (!resetChecked) begin
				resetChecked = 1'b1;
				checkCount++;
				if (inAck !== 1'b0 || rspReq !== 1'b0) begin
					noteFailure("inAck or rspReq was not low after reset");
				end
			end

			if (inAck && !prevInAck) begin
				checkCount++;
				if (!canAccept) begin
					noteFailure("inAck rose without an acceptable request one cycle before");
				end
				base = inData.first ? '0 : modelAcc;   // first clears the running sum
				prodV = $signed(inData.x) * $signed(inData.y);
				modelAcc = base + prodV[macPkg::widthA-1:0];   // mod 2**20
				if (inData.last) begin
					expQ.push_back(modelAcc);
				end
			end else if (canAccept) begin
				noteFailure("inAck did not rise one cycle after an acceptable request");
			end

			if (rspReq && !prevRspReq) begin
				checkCount++;
				heldSum = rspData.sum;
				if (expQ.size() == 0) begin
					noteFailure("rspReq rose with no result due");
				end else begin
					expSum = expQ.pop_front();
					if (rspData.sum !== expSum) begin
						errCount++;
						$display("mismatch in %s: expected %h, actual %h",
							testName, expSum, rspData.sum);
					end
				end
			end else if (rspReq && rspData.sum !== heldSum) begin
				noteFailure("rspData changed while rspReq was waiting for rspAck");
			end else if (!rspReq && prevRspReq && !prevRspAck) begin
				noteFailure("rspReq dropped before rspAck was seen");
			end

			prevInAck = inAck;
			prevRspReq = rspReq;
			prevRspAck = rspAck;
			canAccept = inReq && !inAck && !rspReq && !rspAck;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/macTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module macTop (
	input  logic          clk,
	input  logic          rstN,
	input  logic          inReq,
	input  macPkg::macReq inData,
	output logic          inAck,
	output logic          rspReq,
	output macPkg::macRsp rspData,
	input  logic          rspAck
);

	macPkg::opX   mulX;
	macPkg::opY   mulY;
	macPkg::accum augend;
	macPkg::accum mulSum;

	macSequencer seq (
		.clk    (clk),
		.rstN   (rstN),
		.inReq  (inReq),
		.inData (inData),
		.inAck  (inAck),
		.rspReq (rspReq),
		.rspData(rspData),
		.rspAck (rspAck),
		.mulX   (mulX),
		.mulY   (mulY),
		.augend (augend),
		.mulSum (mulSum)
	);

	// sklansky prefix, tree compressors
	mulAddSgn #(
		.speed(2)
	) mulAdd (
		.x(mulX),
		.y(mulY),
		.a(augend),
		.p(mulSum)
	);

endmodule

`default_nettype wire

// ==== hdl/macSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module macSequencer (
	input  logic          clk,
	input  logic          rstN,
	input  logic          inReq,
	input  macPkg::macReq inData,
	output logic          inAck,
	output logic          rspReq,
	output macPkg::macRsp rspData,
	input  logic          rspAck,
	output macPkg::opX    mulX,     // to the multiplier-adder
	output macPkg::opY    mulY,
	output macPkg::accum  augend,
	input  macPkg::accum  mulSum    // mulX * mulY + augend
);

	macPkg::seqState state;
	macPkg::seqState stateNext;
	macPkg::accum    acc;
	logic            accept;

	// idle already implies inAck and rspReq low
	assign accept = (state == macPkg::idle) && inReq && !rspAck;

	assign mulX = inData.x;
	assign mulY = inData.y;
	assign augend = inData.first ? '0 : acc;   // first drops the old sum

	always_comb begin
		stateNext = state;
		case (state)
			macPkg::idle: begin
				if (accept) begin
					stateNext = inData.last ? macPkg::resultHeld : macPkg::accepted;
				end
			end
			macPkg::accepted: begin
				if (!inReq) begin
					stateNext = macPkg::idle;
				end
			end
			macPkg::resultHeld: begin
				// input side may still be mid handshake
				if (rspAck) begin
					stateNext = (inAck && inReq) ? macPkg::accepted : macPkg::idle;
				end
			end
			default: stateNext = macPkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= macPkg::idle;
			inAck <= 1'b0;
			rspReq <= 1'b0;
			acc <= '0;
		end else begin
			state <= stateNext;
			if (accept) begin
				inAck <= 1'b1;
				acc <= mulSum;            // new running sum
			end else if (!inReq) begin
				inAck <= 1'b0;            // phase four of the input side
			end
			if (accept && inData.last) begin
				rspReq <= 1'b1;
			end else if (rspAck) begin
				rspReq <= 1'b0;
			end
		end
	end

	// result held until the next last
	always_ff @(posedge clk) begin
		if (accept && inData.last) begin
			rspData.sum <= mulSum;
		end
	end

	inDataHold: assert property (@(posedge clk) disable iff (!rstN)
		inReq && !inAck |=> inAck || $stable(inData))
		else $error("inData changed while the request was still open");

	rspHold: assert property (@(posedge clk) disable iff (!rstN)
		rspReq && !rspAck |=> rspReq && $stable(rspData))
		else $error("rspReq or rspData moved before rspAck");

	// port view, both handshakes idle and a request waiting
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(inAck) |-> $past(inReq && !inAck && !rspReq && !rspAck))
		else $error("inAck rose without an acceptable request");

endmodule

`default_nettype wire

// ==== hdl/mulAddSgn.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulAddSgn #(
	parameter int speed = 2   // passed to the compressors and the final adder
) (
	input  macPkg::opX   x,   // multiplier
	input  macPkg::opY   y,   // multiplicand
	input  macPkg::accum a,   // augend
	output macPkg::accum p    // x * y + a
);

	macPkg::ppRows pp;
	macPkg::prod   ppSum;
	macPkg::prod   ppCarry;
	macPkg::accum  extSum;
	macPkg::accum  extCarry;
	macPkg::accum  csaSum;
	macPkg::accum  csaCarryRaw;
	macPkg::accum  csaCarry;

	mulPPGenSgn ppGen (
		.x (x),
		.y (y),
		.pp(pp)
	);

	// ten rows down to sum and carry
	addMopCsv #(
		.speed(speed)
	) ppTree (
		.rows (pp),
		.sum  (ppSum),
		.carry(ppCarry)
	);

	// sign extension, sum counts as signed, carry as unsigned
	// ones in the carry cancel the 2**16 offset of the rows
	assign extSum = {{(macPkg::widthA-macPkg::widthP-1){1'b0}}, ~ppSum[macPkg::widthP-1], ppSum};
	assign extCarry = {{(macPkg::widthA-macPkg::widthP){1'b1}}, ppCarry};

	// 3:2 row for the augend
	assign csaSum = a ^ extSum ^ extCarry;
	assign csaCarryRaw = (a & extSum) | (extCarry & (a ^ extSum));
	assign csaCarry = {csaCarryRaw[macPkg::widthA-2:0], 1'b0};   // top carry wraps

	prefixAdder #(
		.speed(speed)
	) finalAdd (
		.a(csaSum),
		.b(csaCarry),
		.s(p)
	);

endmodule

`default_nettype wire

// ==== hdl/prefixAdder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefixAdder #(
	parameter int speed = 2   // 0 serial prefix, 2 sklansky
) (
	input  macPkg::accum a,
	input  macPkg::accum b,
	output macPkg::accum s    // a + b mod 2**20
);

	macPkg::accum gen;
	macPkg::accum prop;
	macPkg::accum half;
	macPkg::accum grpGen;     // carry out of bits [i:0]

	assign gen = a & b;
	assign prop = a | b;      // or form, enough for the carries
	assign half = a ^ b;

	if (speed == 0) begin : serialPrefix
		always_comb begin
			grpGen[0] = gen[0];
			for (int i = 1; i < macPkg::widthA; i++) begin
				grpGen[i] = gen[i] | (prop[i] & grpGen[i-1]);   // one node per bit
			end
		end
	end else begin : sklanskyPrefix
		logic [macPkg::prefixLevels:0][macPkg::widthA-1:0] gLvl;
		logic [macPkg::prefixLevels:0][macPkg::widthA-1:0] pLvl;

		always_comb begin
			int j;

			j = 0;
			gLvl[0] = gen;
			pLvl[0] = prop;
			for (int l = 1; l <= macPkg::prefixLevels; l++) begin
				gLvl[l] = gLvl[l-1];   // lower half of each group passes through
				pLvl[l] = pLvl[l-1];
				for (int i = 0; i < macPkg::widthA; i++) begin
					if (((i >> (l - 1)) % 2) == 1) begin
						// upper half joins the top bit of the lower half
						j = ((i >> (l - 1)) << (l - 1)) - 1;
						gLvl[l][i] = gLvl[l-1][i] | (pLvl[l-1][i] & gLvl[l-1][j]);
						pLvl[l][i] = pLvl[l-1][i] & pLvl[l-1][j];
					end
				end
			end
		end

		assign grpGen = gLvl[macPkg::prefixLevels];
	end

	// carry into bit i is the group generate of bits below
	assign s = half ^ {grpGen[macPkg::widthA-2:0], 1'b0};

endmodule

`default_nettype wire

// ==== hdl/addMopCsv.sv ====
`timescale 1ns/1ps
`default_nettype none

module addMopCsv #(
	parameter int speed = 1   // 0 linear slices, otherwise trees
) (
	input  macPkg::ppRows rows,
	output macPkg::prod   sum,
	output macPkg::prod   carry   // already weighted, bit 0 is zero
);

	logic [macPkg::widthP-1:0][macPkg::numRows-1:0] byWeight;  // column i, bit k of row k
	macPkg::prod carryRaw;                                      // before the shift

	// regroup by weight
	always_comb begin
		for (int i = 0; i < macPkg::widthP; i++) begin
			for (int k = 0; k < macPkg::numRows; k++) begin
				byWeight[i][k] = rows[k][i];
			end
		end
	end

	for (genvar i = 0; i < macPkg::widthP; i++) begin : bits
		logic [macPkg::numRows-4:0] cIn;
		logic [macPkg::numRows-4:0] cOut;   // top slice's carries fall off at 2**16

		if (i == 0) begin : bottom
			assign cIn = '0;
		end else begin : upper
			assign cIn = bits[i-1].cOut;
		end

		compressorSlice #(
			.speed(speed == 0 ? 0 : 1)
		) slice (
			.bitsIn    (byWeight[i]),
			.carryIn   (cIn),
			.sumOut    (sum[i]),
			.carryOut  (carryRaw[i]),
			.carriesOut(cOut)
		);
	end

	assign carry = {carryRaw[macPkg::widthP-2:0], 1'b0};   // msb carry wraps out

endmodule

`default_nettype wire

// ==== hdl/compressorSlice.sv ====
`timescale 1ns/1ps
`default_nettype none

module compressorSlice #(
	parameter int speed = 1   // 0 linear chain, otherwise tree
) (
	input  logic [macPkg::numRows-1:0] bitsIn,      // all bits of one weight
	input  logic [macPkg::numRows-4:0] carryIn,     // from the slice one weight below
	output logic                       sumOut,
	output logic                       carryOut,    // to the next weight
	output logic [macPkg::numRows-4:0] carriesOut   // intermediate carries, next weight
);

	logic [3*macPkg::numRows-6:0] fifo;      // inputs first, then sums and parked carries
	logic [macPkg::numRows-3:0]   faCarry;   // one per full adder

	always_comb begin
		logic a;
		logic b;
		logic c;

		fifo[macPkg::numRows-1:0] = bitsIn;
		// carries in sit in the odd slots behind the inputs
		for (int i = 0; i < macPkg::numRows-3; i++) begin
			fifo[macPkg::numRows+2*i+1] = carryIn[i];
		end

		for (int i = 0; i < macPkg::numRows-2; i++) begin
			if (speed == 0 && i > 0) begin
				// linear: running sum + parked carry + next input bit
				a = fifo[i+2];
				b = fifo[macPkg::numRows+2*i-1];
				c = fifo[macPkg::numRows+2*i-2];
			end else begin
				// tree: always the oldest three entries
				a = fifo[3*i];
				b = fifo[3*i+1];
				c = fifo[3*i+2];
			end
			fifo[macPkg::numRows+2*i] = a ^ b ^ c;         // sum appended to the fifo
			faCarry[i] = (a & b) | (c & (a ^ b));
		end
	end

	assign sumOut = fifo[3*macPkg::numRows-6];               // last appended sum
	assign carryOut = faCarry[macPkg::numRows-3];            // carry of the final adder
	assign carriesOut = faCarry[macPkg::numRows-4:0];

endmodule

`default_nettype wire

// ==== hdl/mulPPGenSgn.sv ====
`timescale 1ns/1ps
`default_nettype none

module mulPPGenSgn (
	input  macPkg::opX    x,    // multiplier
	input  macPkg::opY    y,    // multiplicand
	output macPkg::ppRows pp    // rows to be summed mod 2**16
);

	// baugh-wooley, rows sum to product + 2**16
	always_comb begin
		pp = '0;

		// plain bit products, sign column of y inverted on x
		for (int i = 0; i < macPkg::widthX-1; i++) begin
			for (int k = 0; k < macPkg::widthY-1; k++) begin
				pp[i][i+k] = x[i] & y[k];
			end
			pp[i][i+macPkg::widthY-1] = ~x[i] & y[macPkg::widthY-1];
		end

		// sign row of x, magnitude bits of y inverted
		for (int k = 0; k < macPkg::widthY-1; k++) begin
			pp[macPkg::widthX-1][macPkg::widthX-1+k] = x[macPkg::widthX-1] & ~y[k];
		end
		// both sign bits, positive weight
		pp[macPkg::widthX-1][macPkg::widthP-2] = x[macPkg::widthX-1] & y[macPkg::widthY-1];

		// correction for the inverted x sign row
		pp[macPkg::widthX][macPkg::widthP-2] = ~x[macPkg::widthX-1];
		pp[macPkg::widthX][macPkg::widthX-1] = x[macPkg::widthX-1];

		// correction for the inverted y sign column
		pp[macPkg::widthX+1][macPkg::widthP-1] = 1'b1;   // constant, sets the 2**16 offset
		pp[macPkg::widthX+1][macPkg::widthP-2] = ~y[macPkg::widthY-1];
		pp[macPkg::widthX+1][macPkg::widthY-1] = y[macPkg::widthY-1];
	end

endmodule

`default_nettype wire

// ==== hdl/macPkg.sv ====
`default_nettype none

package macPkg;

	localparam int widthX = 8;                        // multiplier
	localparam int widthY = 8;                        // multiplicand
	localparam int widthP = widthX + widthY;          // full product
	localparam int widthA = 20;                       // accumulator, augend and sum
	localparam int numRows = widthX + 2;              // bit product rows plus two correction rows
	localparam int prefixLevels = $clog2(widthA);     // depth of the sklansky tree

	typedef logic [widthX-1:0] opX;                   // signed multiplier
	typedef logic [widthY-1:0] opY;                   // signed multiplicand
	typedef logic [widthP-1:0] prod;                  // one partial product row
	typedef logic [widthA-1:0] accum;                 // wraps mod 2**20
	typedef logic [numRows-1:0][widthP-1:0] ppRows;   // row k at index k

	// one request on the input port
	typedef struct packed {
		opX   x;
		opY   y;
		logic first;   // start a new sum
		logic last;    // return the sum after this product
	} macReq;

	// one result on the output port
	typedef struct packed {
		accum sum;
	} macRsp;

	// sequencer states
	typedef enum logic [1:0] {
		idle,          // inAck and rspReq both low
		accepted,      // inAck high, waiting for inReq to drop
		resultHeld     // rspReq high, waiting for rspAck
	} seqState;

endpackage

`default_nettype wire
